// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = tb_vt52
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Test failed" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== source/vt52_char_writer.sv ====
// vt52_char_writer: registered character writes and the blank-fill erase loop
`timescale 1ns/1ps
`default_nettype none

`include "vt52_defines.svh"

module vt52_char_writer (
   input  wire                           clk,
   input  wire                           reset,
   input  wire vt52_cmd_pkg::cmd_t       cmd,
   input  wire vt52_screen_pkg::char_t   cmd_char,
   input  wire vt52_screen_pkg::addr_t   char_addr,
   input  wire                           erase_req,
   input  wire vt52_screen_pkg::addr_t   erase_first,
   input  wire vt52_screen_pkg::addr_t   erase_last,
   output vt52_screen_pkg::char_t        new_char,
   output vt52_screen_pkg::addr_t        new_char_address,
   output logic                          new_char_wen,
   output logic                          erase_busy
);
   import vt52_screen_pkg::*;
   import vt52_cmd_pkg::*;

   localparam addr_t last_addr = addr_t'(`VT52_BUF_SIZE - 1);

   addr_t erase_end;
   logic  erase_done;

   assign erase_done = (new_char_address == erase_end);

   always_ff @(posedge clk) begin
      if (reset) begin
         new_char_wen <= 1'b0;
         erase_busy <= 1'b0;
      end else begin
         new_char_wen <= 1'b0;
         if (erase_req) begin
            erase_busy <= 1'b1;
            new_char_wen <= 1'b1;
         end else if (cmd == cmd_print) begin
            new_char_wen <= 1'b1;
         end else if (erase_busy) begin
            // busy drops right after the last blank is written
            if (erase_done) begin
               erase_busy <= 1'b0;
            end else begin
               new_char_wen <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (erase_req) begin
         new_char <= `VT52_BLANK;
         new_char_address <= erase_first;
         erase_end <= erase_last;
      end else if (cmd == cmd_print) begin
         new_char <= cmd_char;
         new_char_address <= char_addr;
      end else if (erase_busy && !erase_done) begin
         new_char_address <= (new_char_address == last_addr) ? '0 :
                             new_char_address + addr_t'(1);
      end
   end

   // the decoder holds off input for the whole erase
   assert property (@(posedge clk) disable iff (reset) erase_req |-> !erase_busy)
      else $error("erase request during an erase");

endmodule

`default_nettype wire

// ==== source/vt52_cmd_pkg.sv ====
// decoded command and decoder state enums
`default_nettype none

package vt52_cmd_pkg;

   // one command per accepted byte, cmd_none when idle
   typedef enum logic [3:0] {
      cmd_none, cmd_print, cmd_backspace, cmd_tab,
      cmd_linefeed, cmd_return,
      cmd_up, cmd_down, cmd_right, cmd_left,
      cmd_home, cmd_goto,
      cmd_erase_line, cmd_erase_screen,
      cmd_graph_on, cmd_graph_off
   } cmd_t;

   // byte-stream decoder states
   typedef enum logic [1:0] {
      dec_normal,
      dec_escape,
      dec_get_row,
      dec_get_col
   } dec_state_t;

endpackage

`default_nettype wire

// ==== source/vt52_command_handler.sv ====
// vt52_command_handler: top level joining decoder, cursor control and character writer
`timescale 1ns/1ps
`default_nettype none

module vt52_command_handler (
   input  wire                           clk,
   input  wire                           reset,
   input  wire vt52_screen_pkg::char_t   data,
   input  wire                           valid,
   output logic                          ready,
   output vt52_screen_pkg::addr_t        new_first_char,
   output logic                          new_first_char_wen,
   output vt52_screen_pkg::char_t        new_char,
   output vt52_screen_pkg::addr_t        new_char_address,
   output logic                          new_char_wen,
   output vt52_screen_pkg::col_t         new_cursor_x,
   output vt52_screen_pkg::row_t         new_cursor_y,
   output logic                          new_cursor_wen,
   output logic                          graphic_mode
);
   import vt52_screen_pkg::*;
   import vt52_cmd_pkg::*;

   cmd_t  cmd;
   char_t cmd_char;
   row_t  goto_row;
   logic  goto_row_keep;
   col_t  goto_col;
   addr_t char_addr;
   logic  erase_req;
   addr_t erase_first;
   addr_t erase_last;
   logic  erase_busy;
   logic  move_busy;

   vt52_decoder u_decoder (
      .clk(clk), .reset(reset), .data(data), .valid(valid),
      .erase_busy(erase_busy), .move_busy(move_busy), .ready(ready),
      .cmd(cmd), .cmd_char(cmd_char), .goto_row(goto_row),
      .goto_row_keep(goto_row_keep), .goto_col(goto_col)
   );

   vt52_cursor_ctrl u_cursor_ctrl (
      .clk(clk), .reset(reset), .cmd(cmd), .goto_row(goto_row),
      .goto_row_keep(goto_row_keep), .goto_col(goto_col), .char_addr(char_addr),
      .cursor_x(new_cursor_x), .cursor_y(new_cursor_y), .cursor_wen(new_cursor_wen),
      .first_char(new_first_char), .first_char_wen(new_first_char_wen),
      .graphic_mode(graphic_mode), .erase_req(erase_req), .erase_first(erase_first),
      .erase_last(erase_last), .move_busy(move_busy)
   );

   vt52_char_writer u_char_writer (
      .clk(clk), .reset(reset), .cmd(cmd), .cmd_char(cmd_char), .char_addr(char_addr),
      .erase_req(erase_req), .erase_first(erase_first), .erase_last(erase_last),
      .new_char(new_char), .new_char_address(new_char_address),
      .new_char_wen(new_char_wen), .erase_busy(erase_busy)
   );

endmodule

`default_nettype wire

// ==== source/vt52_cursor_ctrl.sv ====
// vt52_cursor_ctrl: cursor, row address, scroll origin, Esc Y pipeline and erase ranges
`timescale 1ns/1ps
`default_nettype none

`include "vt52_defines.svh"

module vt52_cursor_ctrl (
   input  wire                           clk,
   input  wire                           reset,
   input  wire vt52_cmd_pkg::cmd_t       cmd,
   input  wire vt52_screen_pkg::row_t    goto_row,
   input  wire                           goto_row_keep,
   input  wire vt52_screen_pkg::col_t    goto_col,
   output vt52_screen_pkg::addr_t        char_addr,
   output vt52_screen_pkg::col_t         cursor_x,
   output vt52_screen_pkg::row_t         cursor_y,
   output logic                          cursor_wen,
   output vt52_screen_pkg::addr_t        first_char,
   output logic                          first_char_wen,
   output logic                          graphic_mode,
   output logic                          erase_req,
   output vt52_screen_pkg::addr_t        erase_first,
   output vt52_screen_pkg::addr_t        erase_last,
   output logic                          move_busy
);
   import vt52_screen_pkg::*;
   import vt52_cmd_pkg::*;

   localparam col_t  last_col = col_t'(`VT52_COLS - 1);
   localparam row_t  last_row = row_t'(`VT52_ROWS - 1);
   localparam addr_t last_row_addr = addr_t'(`VT52_LAST_ROW);
   localparam addr_t row_step = addr_t'(`VT52_COLS);

   addr_t      row_addr;
   addr_t      row_addr_next;
   col_t       x_next;
   row_t       y_next;
   addr_t      first_next;
   row_t       goto_row_eff;
   logic       goto_s1;
   logic       goto_s2;
   wide_addr_t goto_sum;
   addr_t      goto_addr;
   row_t       goto_y;
   col_t       goto_x;

   // row start addresses wrap around the circular buffer
   function automatic addr_t row_below(input addr_t a);
      return (a == last_row_addr) ? addr_t'(0) : a + row_step;
   endfunction

   function automatic addr_t row_above(input addr_t a);
      return (a == addr_t'(0)) ? last_row_addr : a - row_step;
   endfunction

   // a row never straddles the wrap point, so no reduction here
   assign char_addr = row_addr + addr_t'(cursor_x);
   assign move_busy = goto_s1 || goto_s2;
   assign goto_row_eff = goto_row_keep ? cursor_y : goto_row;

   always_comb begin
      x_next = cursor_x;
      y_next = cursor_y;
      row_addr_next = row_addr;
      first_next = first_char;
      case (cmd)
         // no wrap at the last column
         cmd_print, cmd_right: begin
            if (cursor_x != last_col) x_next = cursor_x + col_t'(1);
         end
         cmd_backspace, cmd_left: begin
            if (cursor_x != '0) x_next = cursor_x - col_t'(1);
         end
         cmd_tab: begin
            if (cursor_x <= col_t'(`VT52_TAB_LIMIT)) begin
               x_next = {cursor_x[6:3] + 4'd1, 3'b000};
            end else if (cursor_x != last_col) begin
               x_next = cursor_x + col_t'(1);
            end
         end
         cmd_return: x_next = '0;
         cmd_linefeed: begin
            // bottom row scrolls the origin instead of moving the cursor
            if (cursor_y == last_row) begin
               first_next = row_below(first_char);
            end else begin
               y_next = cursor_y + row_t'(1);
            end
            row_addr_next = row_below(row_addr);
         end
         cmd_down: begin
            if (cursor_y != last_row) begin
               y_next = cursor_y + row_t'(1);
               row_addr_next = row_below(row_addr);
            end
         end
         cmd_up: begin
            if (cursor_y != '0) begin
               y_next = cursor_y - row_t'(1);
               row_addr_next = row_above(row_addr);
            end
         end
         cmd_home: begin
            x_next = '0;
            y_next = '0;
            row_addr_next = first_char;
         end
         default: ;
      endcase
      // last Esc Y step, input is stalled so no command competes
      if (goto_s2) begin
         x_next = goto_x;
         y_next = goto_y;
         row_addr_next = goto_addr;
      end
   end

   always_comb begin
      erase_req = 1'b0;
      erase_first = char_addr;
      erase_last = row_addr + addr_t'(last_col);
      case (cmd)
         cmd_erase_line: erase_req = 1'b1;
         cmd_erase_screen: begin
            erase_req = 1'b1;
            erase_last = (first_char == '0) ? addr_t'(`VT52_BUF_SIZE - 1) :
                         first_char - addr_t'(1);
         end
         cmd_linefeed: begin
            // old top row becomes the new bottom row
            if (cursor_y == last_row) begin
               erase_req = 1'b1;
               erase_first = first_char;
               erase_last = first_char + addr_t'(last_col);
            end
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         cursor_x <= '0;
         cursor_y <= '0;
         row_addr <= '0;
         first_char <= '0;
         cursor_wen <= 1'b0;
         first_char_wen <= 1'b0;
         graphic_mode <= 1'b0;
         goto_s1 <= 1'b0;
         goto_s2 <= 1'b0;
      end else begin
         cursor_x <= x_next;
         cursor_y <= y_next;
         row_addr <= row_addr_next;
         first_char <= first_next;
         cursor_wen <= (x_next != cursor_x) || (y_next != cursor_y);
         first_char_wen <= (first_next != first_char);
         if (cmd == cmd_graph_on) begin
            graphic_mode <= 1'b1;
         end else if (cmd == cmd_graph_off) begin
            graphic_mode <= 1'b0;
         end
         goto_s1 <= (cmd == cmd_goto);
         goto_s2 <= goto_s1;
      end
   end

   // Esc Y: multiply and add first, then reduce modulo the buffer size
   always_ff @(posedge clk) begin
      if (cmd == cmd_goto) begin
         goto_y <= goto_row_eff;
         goto_x <= goto_col;
         goto_sum <= wide_addr_t'(goto_row_eff) * wide_addr_t'(`VT52_COLS) +
                     wide_addr_t'(first_char);
      end
      if (goto_s1) begin
         goto_addr <= (goto_sum >= wide_addr_t'(`VT52_BUF_SIZE)) ?
                      addr_t'(goto_sum - wide_addr_t'(`VT52_BUF_SIZE)) : addr_t'(goto_sum);
      end
   end

   assert property (@(posedge clk) disable iff (reset) cursor_x <= last_col)
      else $error("cursor_x beyond last column: %h", cursor_x);

endmodule

`default_nettype wire

// ==== source/vt52_decoder.sv ====
// vt52_decoder: byte-stream FSM for control codes and escape sequences, drives ready
`timescale 1ns/1ps
`default_nettype none

`include "vt52_defines.svh"

module vt52_decoder (
   input  wire                           clk,
   input  wire                           reset,
   input  wire vt52_screen_pkg::char_t   data,
   input  wire                           valid,
   input  wire                           erase_busy,
   input  wire                           move_busy,
   output logic                          ready,
   output vt52_cmd_pkg::cmd_t            cmd,
   output vt52_screen_pkg::char_t        cmd_char,
   output vt52_screen_pkg::row_t         goto_row,
   output logic                          goto_row_keep,
   output vt52_screen_pkg::col_t         goto_col
);
   import vt52_screen_pkg::*;
   import vt52_cmd_pkg::*;

   dec_state_t state;
   dec_state_t state_next;
   row_t       row_q;
   logic       row_keep_q;
   logic       accept;
   logic       printable;
   char_t      offset;

   // no new byte while an erase or an Esc Y move is in progress
   assign ready = !erase_busy && !move_busy;
   assign accept = valid && ready;
   assign printable = (data >= 8'h20) && (data <= 8'h7e);

   // Esc Y coordinates come offset by a blank, codes below it wrap to large values
   assign offset = data - `VT52_BLANK;

   assign cmd_char = data;
   assign goto_row = row_q;
   assign goto_row_keep = row_keep_q;
   assign goto_col = (offset < char_t'(`VT52_COLS)) ? col_t'(offset) :
                     col_t'(`VT52_COLS - 1);

   always_comb begin
      cmd = cmd_none;
      state_next = state;
      if (accept) begin
         case (state)
            dec_normal: begin
               if (printable) begin
                  cmd = cmd_print;
               end else begin
                  case (data)
                     8'h08: cmd = cmd_backspace;
                     8'h09: cmd = cmd_tab;
                     8'h0a: cmd = cmd_linefeed;
                     8'h0d: cmd = cmd_return;
                     8'h1b: state_next = dec_escape;
                     default: cmd = cmd_none;
                  endcase
               end
            end
            dec_escape: begin
               state_next = dec_normal;
               case (data)
                  "A": cmd = cmd_up;
                  "B": cmd = cmd_down;
                  "C": cmd = cmd_right;
                  "D": cmd = cmd_left;
                  "H": cmd = cmd_home;
                  "K": cmd = cmd_erase_line;
                  "J": cmd = cmd_erase_screen;
                  "F": cmd = cmd_graph_on;
                  "G": cmd = cmd_graph_off;
                  "Y": state_next = dec_get_row;
                  // a second Esc does not cancel the first
                  8'h1b: state_next = dec_escape;
                  default: cmd = cmd_none;
               endcase
            end
            dec_get_row: begin
               state_next = dec_get_col;
            end
            dec_get_col: begin
               cmd = cmd_goto;
               state_next = dec_normal;
            end
            default: state_next = dec_normal;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= dec_normal;
      end else begin
         state <= state_next;
      end
   end

   // row byte kept until the column byte completes Esc Y
   always_ff @(posedge clk) begin
      if (accept && (state == dec_get_row)) begin
         row_q <= row_t'(offset);
         row_keep_q <= (offset >= char_t'(`VT52_ROWS));
      end
   end

   // erase and Esc Y move never run together
   assert property (@(posedge clk) disable iff (reset) !(erase_busy && move_busy))
      else $error("erase and Esc Y move busy at the same time");

endmodule

`default_nettype wire

// ==== source/vt52_defines.svh ====
// screen geometry, buffer size, tab stop and blank character macros
`ifndef VT52_DEFINES_SVH
`define VT52_DEFINES_SVH

// visible screen size
`define VT52_ROWS 24
`define VT52_COLS 80

// first cell of the last row in the circular buffer
`define VT52_LAST_ROW 1840

// total number of character cells
`define VT52_BUF_SIZE 1920

// tab jumps to the next stop up to this column, single steps after it
`define VT52_TAB_LIMIT 71

`define VT52_BLANK 8'h20

`endif

// ==== source/vt52_screen_pkg.sv ====
// screen geometry types: rows, columns, buffer addresses and characters
`default_nettype none

package vt52_screen_pkg;

   // cursor coordinates
   typedef logic [4:0] row_t;
   typedef logic [6:0] col_t;

   // cell address in the circular buffer
   typedef logic [10:0] addr_t;

   // one extra bit, an address sum before it is reduced modulo the buffer size
   typedef logic [11:0] wide_addr_t;

   typedef logic [7:0] char_t;

endpackage

`default_nettype wire

// ==== sources.f ====
+incdir+source
source/vt52_screen_pkg.sv
source/vt52_cmd_pkg.sv
source/vt52_decoder.sv
source/vt52_cursor_ctrl.sv
source/vt52_char_writer.sv
source/vt52_command_handler.sv
verif/vt52_checker.sv
verif/tb_vt52.sv

// ==== verif/tb_vt52.sv ====
// tb_vt52: clock, reset, stimulus table, byte driver and timeout around the command handler
`timescale 1ns/1ps
`default_nettype none

module tb_vt52;
   import vt52_screen_pkg::*;

   localparam int max_rows = 128;

   logic        clk = 1'b0;
   logic        reset;
   char_t       data;
   logic        valid;
   logic        ready;
   addr_t       new_first_char;
   logic        new_first_char_wen;
   char_t       new_char;
   addr_t       new_char_address;
   logic        new_char_wen;
   col_t        new_cursor_x;
   row_t        new_cursor_y;
   logic        new_cursor_wen;
   logic        graphic_mode;
   logic        check_now;
   col_t        exp_x;
   row_t        exp_y;
   addr_t       exp_first;
   logic        exp_gm;
   addr_t       probe_addr;
   char_t       probe_char;
   int          value_errors;
   int          other_errors;
   int          n_rows = 0;
   int          limit = 0;
   int          cycles = 0;

   // one entry per byte, expected values only matter on checkpoint rows
   char_t tbl_byte  [0:max_rows-1];
   logic  tbl_chk   [0:max_rows-1];
   col_t  tbl_x     [0:max_rows-1];
   row_t  tbl_y     [0:max_rows-1];
   addr_t tbl_first [0:max_rows-1];
   logic  tbl_gm    [0:max_rows-1];
   addr_t tbl_paddr [0:max_rows-1];
   char_t tbl_pchar [0:max_rows-1];

   vt52_command_handler uut (
      .clk(clk), .reset(reset), .data(data), .valid(valid), .ready(ready),
      .new_first_char(new_first_char), .new_first_char_wen(new_first_char_wen),
      .new_char(new_char), .new_char_address(new_char_address),
      .new_char_wen(new_char_wen), .new_cursor_x(new_cursor_x),
      .new_cursor_y(new_cursor_y), .new_cursor_wen(new_cursor_wen),
      .graphic_mode(graphic_mode)
   );

   vt52_checker u_check (
      .clk(clk), .reset(reset), .valid(valid), .data(data), .ready(ready),
      .new_first_char(new_first_char), .new_first_char_wen(new_first_char_wen),
      .new_char(new_char), .new_char_address(new_char_address),
      .new_char_wen(new_char_wen), .new_cursor_x(new_cursor_x),
      .new_cursor_y(new_cursor_y), .new_cursor_wen(new_cursor_wen),
      .graphic_mode(graphic_mode), .check_now(check_now), .exp_x(exp_x), .exp_y(exp_y),
      .exp_first(exp_first), .exp_gm(exp_gm), .probe_addr(probe_addr),
      .probe_char(probe_char),
      .value_errors(value_errors), .other_errors(other_errors)
   );

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= limit) begin
         $display("timeout after %0d cycles, the DUT stopped taking bytes", cycles);
         $display("Test failed");
         $finish;
      end
   end

   task automatic push_seq(input string s);
      for (int k = 0; k < s.len(); k++) begin
         tbl_byte[n_rows] = char_t'(s[k]);
         tbl_chk[n_rows] = 1'b0;
         n_rows++;
      end
   endtask

   task automatic push_chk(input char_t b, input int x, input int y, input int first,
                           input int gm, input int paddr, input char_t pchar);
      tbl_byte[n_rows] = b;
      tbl_chk[n_rows] = 1'b1;
      tbl_x[n_rows] = col_t'(x);
      tbl_y[n_rows] = row_t'(y);
      tbl_first[n_rows] = addr_t'(first);
      tbl_gm[n_rows] = (gm != 0);
      tbl_paddr[n_rows] = addr_t'(paddr);
      tbl_pchar[n_rows] = pchar;
      n_rows++;
   endtask

   // byte, then x, y, first_char, graphic_mode, probe address and probe character
   task automatic fill_table();
      push_seq("A");
      push_chk("B", 2, 0, 0, 0, 1, "B");
      // Esc Y to column 78, the last two writes land on column 79
      push_seq("\033Y nXY");
      push_chk("Z", 79, 0, 0, 0, 79, "Z");
      push_seq("\015");
      push_chk(8'h08, 0, 0, 0, 0, 78, "X");
      push_chk(8'h09, 8, 0, 0, 0, 78, "X");
      // column 70 tabs to 72, then single steps
      push_seq("\033Y f\011");
      push_chk(8'h09, 73, 0, 0, 0, 78, "X");
      push_seq("\015\033A\033");
      push_chk("D", 0, 0, 0, 0, 0, "A");
      push_seq("\033C\033C\033C\033B\033");
      push_chk("B", 3, 2, 0, 0, 0, "A");
      push_seq("\033Y7o\033B\033");
      push_chk("C", 79, 23, 0, 0, 0, "A");
      push_seq("\033H");
      push_chk("Q", 1, 0, 0, 0, 0, "Q");
      // unknown Esc Z prints nothing, Esc Esc B still moves down
      push_seq("\033Z\033\033");
      push_chk("B", 1, 1, 0, 0, 1, "B");
      push_seq("\033Y%*");
      push_chk("M", 11, 5, 0, 0, 410, "M");
      push_seq("\033Y\177");
      push_chk(8'h7f, 79, 5, 0, 0, 410, "M");
      push_seq("\033HT");
      for (int k = 0; k < 23; k++) begin
         push_seq("\n");
      end
      push_chk(8'h0a, 1, 23, 80, 0, 0, 8'h20);
      push_chk(8'h0a, 1, 23, 160, 0, 79, 8'h20);
      push_seq("KL\033D\033");
      push_chk("K", 2, 23, 160, 0, 82, 8'h20);
      push_seq("\033HP\033");
      push_chk("J", 1, 0, 160, 0, 410, 8'h20);
      push_seq("\033");
      push_chk("F", 1, 0, 160, 1, 160, "P");
      push_seq("\033");
      push_chk("G", 1, 0, 160, 0, 160, "P");
      // row 23 with first_char 160 wraps to address 80
      push_seq("\033Y7 ");
      push_chk("W", 1, 23, 160, 0, 80, "W");
   endtask

   task automatic send_row(input int i);
      int stable;
      stable = 0;
      data <= tbl_byte[i];
      valid <= 1'b1;
      @(posedge clk);
      while (!ready) begin
         @(posedge clk);
      end
      if (tbl_chk[i]) begin
         valid <= 1'b0;
         while (stable < 4) begin
            @(posedge clk);
            stable = ready ? stable + 1 : 0;
         end
         exp_x <= tbl_x[i];
         exp_y <= tbl_y[i];
         exp_first <= tbl_first[i];
         exp_gm <= tbl_gm[i];
         probe_addr <= tbl_paddr[i];
         probe_char <= tbl_pchar[i];
         check_now <= 1'b1;
         @(posedge clk);
         check_now <= 1'b0;
      end
   endtask

   initial begin
      reset = 1'b1;
      data = '0;
      valid = 1'b0;
      check_now = 1'b0;
      exp_x = '0;
      exp_y = '0;
      exp_first = '0;
      exp_gm = 1'b0;
      probe_addr = '0;
      probe_char = '0;
      fill_table();
      limit = n_rows * 100;
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      for (int i = 0; i < n_rows; i++) begin
         send_row(i);
      end
      @(posedge clk);
      $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
      if (value_errors + other_errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verif/vt52_checker.sv ====
// vt52_checker: shadow screen and cursor state, checkpoint comparisons and error counts
`timescale 1ns/1ps
`default_nettype none

`include "vt52_defines.svh"

module vt52_checker (
   input  wire                           clk,
   input  wire                           reset,
   input  wire                           valid,
   input  wire vt52_screen_pkg::char_t   data,
   input  wire                           ready,
   input  wire vt52_screen_pkg::addr_t   new_first_char,
   input  wire                           new_first_char_wen,
   input  wire vt52_screen_pkg::char_t   new_char,
   input  wire vt52_screen_pkg::addr_t   new_char_address,
   input  wire                           new_char_wen,
   input  wire vt52_screen_pkg::col_t    new_cursor_x,
   input  wire vt52_screen_pkg::row_t    new_cursor_y,
   input  wire                           new_cursor_wen,
   input  wire                           graphic_mode,
   input  wire                           check_now,
   input  wire vt52_screen_pkg::col_t    exp_x,
   input  wire vt52_screen_pkg::row_t    exp_y,
   input  wire vt52_screen_pkg::addr_t   exp_first,
   input  wire                           exp_gm,
   input  wire vt52_screen_pkg::addr_t   probe_addr,
   input  wire vt52_screen_pkg::char_t   probe_char,
   output int                            value_errors,
   output int                            other_errors
);
   import vt52_screen_pkg::*;

   localparam addr_t last_addr = addr_t'(`VT52_BUF_SIZE - 1);

   // screen contents as rebuilt from the write pulses
   char_t screen [0:`VT52_BUF_SIZE-1];
   col_t  last_x;
   row_t  last_y;
   addr_t last_first;
   char_t held_char;
   logic  held_print;

   task automatic compare(input string name, input logic [31:0] got,
                          input logic [31:0] expected);
      if (got !== expected) begin
         $display("ERROR %s: got %h expected %h", name, got, expected);
         value_errors = value_errors + 1;
      end
   endtask

   always @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `VT52_BUF_SIZE; i++) begin
            screen[i] <= `VT52_BLANK;
         end
         last_x <= '0;
         last_y <= '0;
         last_first <= '0;
         held_print <= 1'b0;
         held_char <= '0;
         value_errors = 0;
         other_errors = 0;
      end else begin
         // a non-blank printable byte offered during a stall
         held_print <= valid && !ready && (data > `VT52_BLANK) && (data <= 8'h7e);
         held_char <= data;
         if (held_print && new_char_wen && (new_char == held_char)) begin
            $display("handshake failure: a byte offered while ready was low was written");
            other_errors = other_errors + 1;
         end
         if (new_cursor_wen) begin
            last_x <= new_cursor_x;
            last_y <= new_cursor_y;
         end
         if (new_first_char_wen) begin
            last_first <= new_first_char;
         end
         if (new_char_wen) begin
            if (new_char_address > last_addr) begin
               $display("ERROR new_char_address: got %h above %h", new_char_address, last_addr);
               value_errors = value_errors + 1;
            end else begin
               screen[new_char_address] <= new_char;
            end
         end
         if (check_now) begin
            compare("new_cursor_x", 32'(last_x), 32'(exp_x));
            compare("new_cursor_y", 32'(last_y), 32'(exp_y));
            compare("new_first_char", 32'(last_first), 32'(exp_first));
            compare("graphic_mode", 32'(graphic_mode), 32'(exp_gm));
            compare($sformatf("new_char at %h", probe_addr), 32'(screen[probe_addr]),
                    32'(probe_char));
         end
      end
   end

endmodule

`default_nettype wire
